//--- Bender.yml
package:
  name: jam

export_include_dirs:
  - design

sources:
  - design/jamTypesPkg.sv
  - design/jamCtrlPkg.sv
  - design/permutationGenerator.sv
  - design/costQuerySequencer.sv
  - design/costAccumulator.sv
  - design/minCostTracker.sv
  - design/jam.sv
  - target: test
    files:
      - tests/jamCostModel.sv
      - tests/jamTb.sv

//--- design/costAccumulator.sv
module costAccumulator
    import jamTypesPkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  jamCost_t  Cost,
    input  logic      queryValid,
    input  logic      queryLast,
    input  logic      queryFinal,
    output jamTotal_t total,
    output logic      totalValid,
    output logic      totalFinal
);

    // Partial sum of the assignment in flight
    jamTotal_t runSum;
    jamTotal_t sumNext;

    assign sumNext = runSum + jamTotal_t'(Cost);

    // Control and partial sum
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            runSum     <= '0;
            totalValid <= 1'b0;
            totalFinal <= 1'b0;
        end
        else
        begin
            totalValid <= queryValid && queryLast;
            if (queryValid)
            begin
                // Job 7 closes the assignment, restart from zero
                runSum <= queryLast ? '0 : sumNext;
                if (queryLast)
                begin
                    totalFinal <= queryFinal;
                end
            end
        end
    end

    // Completed total, held until the next job 7
    always_ff @(posedge CLK)
    begin
        if (queryValid && queryLast)
        begin
            total <= sumNext;
        end
    end

endmodule

//--- design/costQuerySequencer.sv
`include "jam_params.svh"

module costQuerySequencer
    import jamTypesPkg::*;
    import jamCtrlPkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  jamPerm_t perm,
    input  logic     isLast,
    output jamIdx_t  W,
    output jamIdx_t  J,
    output logic     step,
    output logic     queryValid,
    output logic     queryLast,
    output logic     queryFinal
);

    jamSeqState_t state;
    // Job to be issued at the next edge
    jamIdx_t      jobCnt;
    logic         lastJob;

    assign lastJob = (jobCnt == jamIdx_t'(`JAM_WORKERS - 1));

    // Advance the generator on the edge that registers job 7,
    // W for job 7 still reads the old perm there,
    // and the new perm is ready for the following job 0
    assign step = (state == SeqQuery) && lastJob && !isLast;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state      <= SeqIdle;
            jobCnt     <= '0;
            W          <= '0;
            J          <= '0;
            queryValid <= 1'b0;
            queryLast  <= 1'b0;
            queryFinal <= 1'b0;
        end
        else
        begin
            case (state)
                SeqIdle, SeqQuery:
                begin
                    // One query per edge, no bubbles
                    J          <= jobCnt;
                    W          <= perm[jobCnt];
                    queryValid <= 1'b1;
                    queryLast  <= lastJob;
                    queryFinal <= isLast;
                    // Wraps 7 -> 0 on its own
                    jobCnt     <= jobCnt + 1'b1;
                    if (lastJob && isLast)
                    begin
                        state <= SeqDone;
                    end
                    else
                    begin
                        state <= SeqQuery;
                    end
                end
                SeqDone:
                begin
                    // W and J keep the final query
                    queryValid <= 1'b0;
                    queryLast  <= 1'b0;
                    queryFinal <= 1'b0;
                end
                default:
                begin
                    state <= SeqIdle;
                end
            endcase
        end
    end

    // Job index walks 0..7 without gaps
    jobStepsByOne: assert property (@(posedge CLK) disable iff (RST)
        (state == SeqQuery && $past(state) == SeqQuery) |-> J == jamIdx_t'($past(J) + 1'b1))
        else $error("J skipped from %0d to %0d", $past(J), J);

endmodule

//--- design/jam.sv
module jam
    import jamTypesPkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    output jamIdx_t   W,
    output jamIdx_t   J,
    input  jamCost_t  Cost,
    output jamCount_t MatchCount,
    output jamTotal_t MinCost,
    output logic      Valid
);

    // Generator to sequencer
    jamPerm_t  perm;
    logic      isLast;
    logic      step;

    // Sequencer to accumulator, aligned with W/J
    logic      queryValid;
    logic      queryLast;
    logic      queryFinal;

    // Accumulator to tracker
    jamTotal_t total;
    logic      totalValid;
    logic      totalFinal;

    permutationGenerator permGen (
        .CLK        (CLK),
        .RST        (RST),
        .step       (step),
        .perm       (perm),
        .isLast     (isLast)
    );

    // Drives the cost table address
    costQuerySequencer querySeq (
        .CLK        (CLK),
        .RST        (RST),
        .perm       (perm),
        .isLast     (isLast),
        .W          (W),
        .J          (J),
        .step       (step),
        .queryValid (queryValid),
        .queryLast  (queryLast),
        .queryFinal (queryFinal)
    );

    costAccumulator costAcc (
        .CLK        (CLK),
        .RST        (RST),
        .Cost       (Cost),
        .queryValid (queryValid),
        .queryLast  (queryLast),
        .queryFinal (queryFinal),
        .total      (total),
        .totalValid (totalValid),
        .totalFinal (totalFinal)
    );

    minCostTracker minTrack (
        .CLK        (CLK),
        .RST        (RST),
        .total      (total),
        .totalValid (totalValid),
        .totalFinal (totalFinal),
        .MinCost    (MinCost),
        .MatchCount (MatchCount),
        .Valid      (Valid)
    );

endmodule

//--- design/jamCtrlPkg.sv
package jamCtrlPkg;

    // Query sequencer states
    // Idle only lasts for the first edge after reset
    typedef enum logic [1:0]
    {
        SeqIdle,
        SeqQuery,
        SeqDone
    } jamSeqState_t;

endpackage

//--- design/jamTypesPkg.sv
`include "jam_params.svh"

package jamTypesPkg;

    // Worker or job number
    typedef logic [`JAM_IDX_W-1:0] jamIdx_t;

    // Single cost returned by the table
    typedef logic [`JAM_COST_W-1:0] jamCost_t;

    // Assignment total, also the running minimum
    typedef logic [`JAM_TOTAL_W-1:0] jamTotal_t;

    // Number of assignments that reach the minimum
    typedef logic [`JAM_COUNT_W-1:0] jamCount_t;

    // Current assignment
    // entry j holds the worker that gets job j
    typedef jamIdx_t [`JAM_WORKERS-1:0] jamPerm_t;

endpackage

//--- design/jam_params.svh
`ifndef JAM_PARAMS_SVH
`define JAM_PARAMS_SVH

// Square problem, one job per worker
`define JAM_WORKERS 8

// Index of a worker or a job
`define JAM_IDX_W 3

// One entry of the cost table
`define JAM_COST_W 7

// Sum of eight costs, 8 x 127 fits in 10 bits
`define JAM_TOTAL_W 10

// Tie counter, saturates at all ones
`define JAM_COUNT_W 4

`endif

//--- design/minCostTracker.sv
module minCostTracker
    import jamTypesPkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  jamTotal_t total,
    input  logic      totalValid,
    input  logic      totalFinal,
    output jamTotal_t MinCost,
    output jamCount_t MatchCount,
    output logic      Valid
);

    // Last assignment has been folded in
    logic finalTaken;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            // Above any reachable total
            MinCost    <= '1;
            MatchCount <= '0;
            finalTaken <= 1'b0;
        end
        else if (totalValid)
        begin
            if (total < MinCost)
            begin
                // New best, restart the tie count
                MinCost    <= total;
                MatchCount <= jamCount_t'(1);
            end
            else if (total == MinCost && !(&MatchCount))
            begin
                // Another tie, stop at all ones
                MatchCount <= MatchCount + 1'b1;
            end
            if (totalFinal)
            begin
                finalTaken <= 1'b1;
            end
        end
    end

    // Valid trails the last update by one cycle
    // so MinCost and MatchCount are already settled when it rises
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            Valid <= 1'b0;
        end
        else if (finalTaken)
        begin
            Valid <= 1'b1;
        end
    end

    // Minimum only moves down between resets
    minNeverRises: assert property (@(posedge CLK) disable iff (RST) MinCost <= $past(MinCost))
        else $error("MinCost rose from %0d to %0d", $past(MinCost), MinCost);

endmodule

//--- design/permutationGenerator.sv
`include "jam_params.svh"

module permutationGenerator
    import jamTypesPkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  logic     step,
    output jamPerm_t perm,
    output logic     isLast
);

    // Rightmost ascent position
    jamIdx_t  pivot;
    logic     hasAscent;
    // Rightmost entry above the pivot value
    jamIdx_t  swapIdx;
    jamPerm_t swapped;
    jamPerm_t nextPerm;
    // One bit per worker seen in perm
    logic [`JAM_WORKERS-1:0] seenMask;

    // Scan left to right, last hit wins
    always_comb
    begin
        hasAscent = 1'b0;
        pivot     = '0;
        for (int i = 0; i < `JAM_WORKERS - 1; i++)
        begin
            if (perm[i] < perm[i + 1])
            begin
                hasAscent = 1'b1;
                pivot     = jamIdx_t'(i);
            end
        end
    end

    // Suffix right of the pivot is descending,
    // so the rightmost larger entry is also the smallest larger one
    always_comb
    begin
        swapIdx = pivot;
        for (int k = 1; k < `JAM_WORKERS; k++)
        begin
            if (k > int'(pivot) && perm[k] > perm[pivot])
            begin
                swapIdx = jamIdx_t'(k);
            end
        end
    end

    // Swap, then reverse the suffix
    always_comb
    begin
        swapped          = perm;
        swapped[pivot]   = perm[swapIdx];
        swapped[swapIdx] = perm[pivot];
        nextPerm         = swapped;
        for (int m = 1; m < `JAM_WORKERS; m++)
        begin
            // Position pivot+1 takes entry 7, position 7 takes pivot+1
            if (m > int'(pivot))
            begin
                nextPerm[m] = swapped[`JAM_WORKERS + int'(pivot) - m];
            end
        end
    end

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            // Identity, job j to worker j
            for (int j = 0; j < `JAM_WORKERS; j++)
            begin
                perm[j] <= jamIdx_t'(j);
            end
        end
        else if (step && hasAscent)
        begin
            perm <= nextPerm;
        end
    end

    // No ascent anywhere means fully descending, 7..0
    assign isLast = ~hasAscent;

    always_comb
    begin
        seenMask = '0;
        for (int j = 0; j < `JAM_WORKERS; j++)
        begin
            seenMask[perm[j]] = 1'b1;
        end
    end

    // Every step must keep a true permutation
    permIsBijection: assert property (@(posedge CLK) disable iff (RST) &seenMask)
        else $error("perm lost a worker: %h", perm);

endmodule

//--- files.f
+incdir+design
design/jamTypesPkg.sv
design/jamCtrlPkg.sv
design/permutationGenerator.sv
design/costQuerySequencer.sv
design/costAccumulator.sv
design/minCostTracker.sv
design/jam.sv
tests/jamCostModel.sv
tests/jamTb.sv

//--- tests/jamCostModel.sv
`include "jam_params.svh"

module jamCostModel
    import jamTypesPkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  jamIdx_t   W,
    input  jamIdx_t   J,
    input  logic      Valid,
    // Indexed [worker][job]
    input  jamCost_t [`JAM_WORKERS-1:0][`JAM_WORKERS-1:0] costTable,
    output jamCost_t  Cost,
    output int        errCount,
    output int        jobZeroCount,
    output int        validLag
);

    timeunit 1ns;
    timeprecision 100ps;

    // Eight jobs for each of the 8! assignments
    localparam int QUERY_TOTAL = `JAM_WORKERS * 40320;

    int      queryIdx;
    int      sinceLast;
    jamIdx_t lastW;
    jamIdx_t lastJ;
    // Workers already used in the current group of eight
    logic [`JAM_WORKERS-1:0] groupMask;

    initial
    begin
        Cost         = '0;
        errCount     = 0;
        jobZeroCount = 0;
        validLag     = -1;
        queryIdx     = 0;
        sinceLast    = 0;
        groupMask    = '0;
    end

    task automatic reportMismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errCount++;
    endtask

    always @(negedge CLK)
    begin
        // Answer for the address registered at the last rising edge
        Cost <= costTable[W][J];
        if (RST)
        begin
            queryIdx     = 0;
            sinceLast    = 0;
            jobZeroCount = 0;
            validLag     = -1;
        end
        else if (queryIdx < QUERY_TOTAL)
        begin
            // First sample after reset is already a query
            if (queryIdx % `JAM_WORKERS == 0)
            begin
                groupMask = '0;
            end
            assert (J === jamIdx_t'(queryIdx % `JAM_WORKERS))
                else reportMismatch($sformatf("query %0d has J %0d", queryIdx, J));
            assert (!$isunknown(W) && !groupMask[W])
                else reportMismatch($sformatf("worker %0d repeats in group %0d",
                    W, queryIdx / `JAM_WORKERS));
            assert (Valid === 1'b0)
                else reportMismatch($sformatf("Valid high during query %0d", queryIdx));
            if (!$isunknown(W))
            begin
                groupMask[W] = 1'b1;
            end
            if (J === '0)
            begin
                jobZeroCount++;
            end
            lastW = W;
            lastJ = J;
            queryIdx++;
        end
        else if (validLag < 0)
        begin
            // Done, address must hold the last query
            sinceLast++;
            assert (W === lastW && J === lastJ)
                else reportMismatch($sformatf("W/J moved to %0d/%0d after last query", W, J));
            if (Valid === 1'b1)
            begin
                validLag = sinceLast;
            end
        end
    end

endmodule

//--- tests/jamTb.sv
`include "jam_params.svh"

module jamTb
    import jamTypesPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // 8! assignments
    localparam int PERM_TOTAL    = 40320;
    localparam int VALID_TIMEOUT = 330000;
    localparam int RESET_TIMEOUT = 10;
    localparam int HOLD_CYCLES   = 20;
    localparam int CASE_TOTAL    = 3;
    // Last query cycle ends, then two more edges
    localparam int VALID_LAG     = 3;
    localparam int CASE_NUMBERS  = `JAM_WORKERS * `JAM_WORKERS + 2;

    logic      CLK;
    logic      RST;
    jamIdx_t   W;
    jamIdx_t   J;
    jamCost_t  Cost;
    jamCount_t MatchCount;
    jamTotal_t MinCost;
    logic      Valid;

    // Current case, table indexed [worker][job]
    jamCost_t [`JAM_WORKERS-1:0][`JAM_WORKERS-1:0] costTable;
    jamTotal_t expMin;
    jamCount_t expCount;

    int fd;
    int mismatchCount;
    int timeoutCount;
    int setupCount;
    // From the cost model
    int modelErrors;
    int jobZeroCount;
    int validLag;

    jam UUT (
        .CLK        (CLK),
        .RST        (RST),
        .W          (W),
        .J          (J),
        .Cost       (Cost),
        .MatchCount (MatchCount),
        .MinCost    (MinCost),
        .Valid      (Valid)
    );

    jamCostModel costModel (
        .CLK          (CLK),
        .RST          (RST),
        .W            (W),
        .J            (J),
        .Valid        (Valid),
        .costTable    (costTable),
        .Cost         (Cost),
        .errCount     (modelErrors),
        .jobZeroCount (jobZeroCount),
        .validLag     (validLag)
    );

    // 4 ns period
    always
    begin
        #2 CLK = ~CLK;
    end

    // Next decimal number, lines starting with # are skipped
    task automatic readNumber(output int value, output bit got);
        int code;
        int ch;
        begin
            value = 0;
            code  = $fscanf(fd, "%d", value);
            while (code != 1 && !$feof(fd))
            begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                begin
                    ch = $fgetc(fd);
                end
                code = $fscanf(fd, "%d", value);
            end
            got = (code == 1);
        end
    endtask

    // 64 costs row by row, then MinCost and MatchCount
    task automatic readCase(output bit found, output bit ok);
        int value;
        int n;
        bit got;
        begin
            n   = 0;
            got = 1'b1;
            while (got && n < CASE_NUMBERS)
            begin
                readNumber(value, got);
                if (got)
                begin
                    if (n < `JAM_WORKERS * `JAM_WORKERS)
                    begin
                        costTable[n / `JAM_WORKERS][n % `JAM_WORKERS] = jamCost_t'(value);
                    end
                    else if (n == CASE_NUMBERS - 2)
                    begin
                        expMin = jamTotal_t'(value);
                    end
                    else
                    begin
                        expCount = jamCount_t'(value);
                    end
                    n++;
                end
            end
            found = (n > 0);
            ok    = (n == 0) || (n == CASE_NUMBERS);
        end
    endtask

    task automatic checkResetState(input string when);
        assert (Valid === 1'b0 && MinCost === '1 && MatchCount === '0)
            else
            begin
                $display("mismatch at %0t: %s, Valid %b MinCost %0d MatchCount %0d",
                    $time, when, Valid, MinCost, MatchCount);
                mismatchCount++;
            end
    endtask

    // Two cycles of reset, released on a falling edge
    task automatic applyReset(output bit ok);
        int cycles;
        bit seen;
        begin
            @(negedge CLK);
            RST <= 1'b1;
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < RESET_TIMEOUT)
            begin
                @(negedge CLK);
                cycles++;
                seen = (Valid === 1'b0) && (MinCost === '1) && (MatchCount === '0);
            end
            ok = seen;
            if (!seen)
            begin
                $display("Reset did not clear the outputs within %0d cycles", RESET_TIMEOUT);
                timeoutCount++;
            end
            else
            begin
                while (cycles < 2)
                begin
                    @(negedge CLK);
                    cycles++;
                end
                checkResetState("during reset");
                RST <= 1'b0;
                @(negedge CLK);
                checkResetState("after reset");
            end
        end
    endtask

    task automatic waitForValid(input int caseNum, output bit ok);
        int cycles;
        begin
            cycles = 0;
            while (Valid !== 1'b1 && cycles < VALID_TIMEOUT)
            begin
                @(negedge CLK);
                cycles++;
            end
            ok = (Valid === 1'b1);
            if (!ok)
            begin
                $display("Valid never rose within %0d cycles in case %0d", VALID_TIMEOUT, caseNum);
                timeoutCount++;
            end
        end
    endtask

    // Engine halted, nothing may move
    task automatic checkHold(input int caseNum);
        jamTotal_t minSeen;
        jamCount_t countSeen;
        jamIdx_t   wSeen;
        jamIdx_t   jSeen;
        begin
            minSeen   = MinCost;
            countSeen = MatchCount;
            wSeen     = W;
            jSeen     = J;
            repeat (HOLD_CYCLES)
            begin
                @(negedge CLK);
                assert (Valid === 1'b1 && MinCost === minSeen && MatchCount === countSeen
                        && W === wSeen && J === jSeen)
                    else
                    begin
                        $display("mismatch at %0t: case %0d outputs moved after Valid",
                            $time, caseNum);
                        mismatchCount++;
                    end
            end
        end
    endtask

    task automatic checkResults(input int caseNum);
        assert (MinCost === expMin)
            else
            begin
                $display("mismatch at %0t: case %0d MinCost %0d, expected %0d",
                    $time, caseNum, MinCost, expMin);
                mismatchCount++;
            end
        assert (MatchCount === expCount)
            else
            begin
                $display("mismatch at %0t: case %0d MatchCount %0d, expected %0d",
                    $time, caseNum, MatchCount, expCount);
                mismatchCount++;
            end
        assert (jobZeroCount == PERM_TOTAL)
            else
            begin
                $display("mismatch at %0t: case %0d saw %0d assignments, expected %0d",
                    $time, caseNum, jobZeroCount, PERM_TOTAL);
                mismatchCount++;
            end
        assert (validLag == VALID_LAG)
            else
            begin
                $display("mismatch at %0t: case %0d Valid lag %0d, expected %0d",
                    $time, caseNum, validLag, VALID_LAG);
                mismatchCount++;
            end
    endtask

    initial
    begin
        bit found;
        bit ok;
        int caseNum;
        int errTotal;
        CLK           = 1'b0;
        RST           = 1'b1;
        costTable     = '0;
        expMin        = '0;
        expCount      = '0;
        mismatchCount = 0;
        timeoutCount  = 0;
        setupCount    = 0;
        caseNum       = 0;
        ok            = 1'b1;
        found         = 1'b1;
        fd = $fopen("tests/jam_golden.dat", "r");
        if (fd == 0)
        begin
            $display("Cannot open tests/jam_golden.dat");
            setupCount++;
            found = 1'b0;
        end
        while (found && ok)
        begin
            readCase(found, ok);
            if (!ok)
            begin
                $display("Golden file ends inside case %0d", caseNum + 1);
                setupCount++;
            end
            else if (found)
            begin
                caseNum++;
                // New table is loaded before the reset that starts the search
                applyReset(ok);
                if (ok)
                begin
                    waitForValid(caseNum, ok);
                end
                if (ok)
                begin
                    checkHold(caseNum);
                    checkResults(caseNum);
                end
            end
        end
        if (fd != 0)
        begin
            $fclose(fd);
        end
        if (ok && caseNum != CASE_TOTAL)
        begin
            $display("Golden file holds %0d cases instead of %0d", caseNum, CASE_TOTAL);
            setupCount++;
        end
        errTotal = mismatchCount + modelErrors + timeoutCount + setupCount;
        $display("Errors: %0d mismatch, %0d protocol, %0d timeout, %0d setup",
            mismatchCount, modelErrors, timeoutCount, setupCount);
        if (errTotal == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tests/jam_golden.dat
# Per case: 8 rows of 8 costs, row = worker 0..7, column = job 0..7
# then one line with the expected MinCost and MatchCount
# Unique optimum on the anti-diagonal, the last permutation
40 45 50 55 43 48 53 8
43 48 53 41 46 51 7 44
46 51 56 44 49 6 42 47
49 54 42 47 5 40 45 50
52 40 45 4 55 43 48 53
55 43 3 53 41 46 51 56
41 2 51 56 44 49 54 42
1 49 54 42 47 52 40 45
36 1
# Three optimal assignments in the lower right corner
3 63 66 69 61 64 67 70
65 7 60 63 66 69 61 64
70 62 2 68 60 63 66 69
64 67 70 9 65 68 60 63
69 61 64 67 4 62 65 68
63 66 69 61 64 4 8 62
68 60 63 66 69 2 6 3
62 65 68 60 63 66 8 5
40 3
# Uniform table at full cost, every assignment ties
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
127 127 127 127 127 127 127 127
1016 15
